/* include/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// --------------------------------------------------
// D-cache geometry
// --------------------------------------------------
`define DC_WAYS     2
`define DC_WORDS    16
`define DC_OFFSET_W 3
`define DC_TAG_W    8
`define DC_LINE_W   64

// --------------------------------------------------
// I-cache geometry
// --------------------------------------------------
`define IC_WAYS     2
`define IC_WORDS    16
`define IC_TAG_W    10
`define IC_LINE_W   32
`define IC_USER_W   4

// Clear walk covers both caches with one counter, so depths must agree

`endif

/* src/cache_pkg.sv */
`include "cache_settings.svh"

package cache_pkg;

  // --------------------------------------------------
  // D-cache
  // --------------------------------------------------
  typedef logic [$clog2(`DC_WORDS)+`DC_OFFSET_W-1:0] dc_addr_t;
  typedef logic [$clog2(`DC_WORDS)-1:0] dc_index_t;
  typedef logic [`DC_TAG_W-1:0] dc_tag_t;
  typedef logic [`DC_LINE_W-1:0] dc_data_t;

  typedef struct packed {
    logic valid;
    logic dirty;
  } vldrty_t;

  typedef struct packed {
    dc_tag_t  tag;
    dc_data_t data;
    logic     valid;
    logic     dirty;
  } dc_line_t;

  // One enable per byte of tag and data, one per bit of valid/dirty
  typedef struct packed {
    logic [(`DC_TAG_W+7)/8-1:0]  tag;
    logic [(`DC_LINE_W+7)/8-1:0] data;
    vldrty_t [`DC_WAYS-1:0]      vldrty;
  } dc_be_t;

  typedef struct packed {
    logic [`DC_WAYS-1:0] way;
    logic                we;
    dc_addr_t            addr;
    dc_line_t            wdata;
    dc_be_t              be;
  } dc_req_t;

  // --------------------------------------------------
  // I-cache
  // --------------------------------------------------
  typedef logic [$clog2(`IC_WORDS)-1:0] ic_index_t;
  typedef logic [`IC_TAG_W-1:0] ic_tag_t;

  typedef struct packed {
    logic    valid;
    ic_tag_t tag;
  } ic_tag_word_t;

  typedef struct packed {
    logic [`IC_USER_W-1:0] user;
    logic [`IC_LINE_W-1:0] data;
  } ic_rtrn_t;

  typedef struct packed {
    logic [`IC_WAYS-1:0] way;
    logic                we;
    ic_index_t           index;
    ic_tag_t             tag;
    logic [`IC_WAYS-1:0] valid;
  } ic_tag_req_t;

  typedef struct packed {
    logic [`IC_WAYS-1:0] way;
    logic                we;
    ic_index_t           index;
    ic_rtrn_t            rtrn;
  } ic_data_req_t;

endpackage

/* src/sram.sv */
module sram #(
  parameter int unsigned DATA_W = 32,
  parameter int unsigned USER_W = 1,
  parameter int unsigned WORDS  = 16,
  parameter int unsigned BYTE_W = 8,
  localparam int unsigned ADDR_W = (WORDS > 1) ? $clog2(WORDS) : 1,
  localparam int unsigned LANES  = (DATA_W + BYTE_W - 1) / BYTE_W
) (
  input  logic              clk_i,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [USER_W-1:0] wuser_i,
  input  logic [LANES-1:0]  be_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic [USER_W-1:0] ruser_o
);

  logic [DATA_W-1:0] mem_q [WORDS];
  logic [USER_W-1:0] user_q [WORDS];

  // --------------------------------------------------
  // Write port
  // --------------------------------------------------
  // Last lane may be narrower than BYTE_W, so enables are applied per bit
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < DATA_W; b++) begin
        if (be_i[b / BYTE_W]) begin
          mem_q[addr_i][b] <= wdata_i[b];
        end
      end
      user_q[addr_i] <= wuser_i;
    end
  end

  // --------------------------------------------------
  // Read port
  // --------------------------------------------------
  // Output register only loads on a read, otherwise it holds
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
      ruser_o <= user_q[addr_i];
    end
  end

  // Unknown address on an access would corrupt or read the wrong word
  addr_known_a: assert property (
    @(posedge clk_i) req_i |-> !$isunknown(addr_i)
  ) else $error("sram: unknown address on access");

endmodule

/* src/cache_ram_clear.sv */
`include "cache_settings.svh"

module cache_ram_clear (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  cache_pkg::dc_req_t      dc_req_i,
  input  cache_pkg::ic_tag_req_t  ic_tag_req_i,
  input  cache_pkg::ic_data_req_t ic_data_req_i,
  output cache_pkg::dc_req_t      dc_req_o,
  output cache_pkg::ic_tag_req_t  ic_tag_req_o,
  output cache_pkg::ic_data_req_t ic_data_req_o,
  output logic                    ready_o
);

  import cache_pkg::*;

  typedef enum logic [1:0] {
    IDLE_RESET,
    CLEAR,
    RUN
  } state_e;

  localparam dc_index_t LAST_IDX = dc_index_t'(`DC_WORDS - 1);

  state_e    state_q;
  state_e    state_d;
  dc_index_t idx_q;
  dc_index_t idx_d;

  // --------------------------------------------------
  // Walk sequencer
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    idx_d   = idx_q;
    case (state_q)
      IDLE_RESET: begin
        state_d = CLEAR;
        idx_d   = '0;
      end
      CLEAR: begin
        idx_d = idx_q + 1'b1;
        if (idx_q == LAST_IDX) begin
          state_d = RUN;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE_RESET;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
    end
  end

  assign ready_o = (state_q == RUN);

  // --------------------------------------------------
  // Request mux
  // --------------------------------------------------
  // Controller requests are dropped until the walk is done
  always_comb begin
    dc_req_o      = '0;
    ic_tag_req_o  = '0;
    ic_data_req_o = '0;
    case (state_q)
      CLEAR: begin
        dc_req_o.way          = '1;
        dc_req_o.we           = 1'b1;
        dc_req_o.addr         = {idx_q, {`DC_OFFSET_W{1'b0}}};
        dc_req_o.be           = '1;
        ic_tag_req_o.way      = '1;
        ic_tag_req_o.we       = 1'b1;
        ic_tag_req_o.index    = ic_index_t'(idx_q);
        ic_data_req_o.way     = '1;
        ic_data_req_o.we      = 1'b1;
        ic_data_req_o.index   = ic_index_t'(idx_q);
      end
      RUN: begin
        dc_req_o      = dc_req_i;
        ic_tag_req_o  = ic_tag_req_i;
        ic_data_req_o = ic_data_req_i;
      end
      default: ;
    endcase
  end

  // No index may be skipped during the walk
  clear_step_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (state_q == CLEAR && idx_q != LAST_IDX) |=>
      (state_q == CLEAR && idx_q == $past(idx_q) + 1'b1)
  ) else $error("cache_ram_clear: index skipped during clear walk");

endmodule

/* src/cache_ram_array.sv */
`include "cache_settings.svh"

module cache_ram_array (
  input  logic                                 clk_i,
  input  cache_pkg::dc_req_t                   dc_req_i,
  input  cache_pkg::ic_tag_req_t               ic_tag_req_i,
  input  cache_pkg::ic_data_req_t              ic_data_req_i,
  output cache_pkg::dc_line_t     [`DC_WAYS-1:0] dc_rdata_o,
  output cache_pkg::ic_tag_word_t [`IC_WAYS-1:0] ic_tag_rdata_o,
  output cache_pkg::ic_rtrn_t     [`IC_WAYS-1:0] ic_data_rdata_o
);

  import cache_pkg::*;

  dc_index_t dc_index;

  dc_tag_t  dc_tag_rdata  [`DC_WAYS];
  dc_data_t dc_data_rdata [`DC_WAYS];

  vldrty_t [`DC_WAYS-1:0] vd_wdata;
  vldrty_t [`DC_WAYS-1:0] vd_rdata;

  ic_tag_word_t          ic_tag_rdata  [`IC_WAYS];
  logic [`IC_LINE_W-1:0] ic_data_rdata [`IC_WAYS];
  logic [`IC_USER_W-1:0] ic_user_rdata [`IC_WAYS];

  // Line offset is not part of the RAM index
  assign dc_index = dc_req_i.addr[$bits(dc_addr_t)-1:`DC_OFFSET_W];

  // --------------------------------------------------
  // D-cache tag and data
  // --------------------------------------------------
  for (genvar i = 0; i < `DC_WAYS; i++) begin : gen_dc_way
    sram #(
      .DATA_W(`DC_TAG_W),
      .USER_W(1),
      .WORDS (`DC_WORDS),
      .BYTE_W(8)
    ) tag_sram (
      .clk_i  (clk_i),
      .req_i  (dc_req_i.way[i]),
      .we_i   (dc_req_i.we),
      .addr_i (dc_index),
      .wdata_i(dc_req_i.wdata.tag),
      .wuser_i(1'b0),
      .be_i   (dc_req_i.be.tag),
      .rdata_o(dc_tag_rdata[i]),
      .ruser_o()
    );

    sram #(
      .DATA_W(`DC_LINE_W),
      .USER_W(1),
      .WORDS (`DC_WORDS),
      .BYTE_W(8)
    ) data_sram (
      .clk_i  (clk_i),
      .req_i  (dc_req_i.way[i]),
      .we_i   (dc_req_i.we),
      .addr_i (dc_index),
      .wdata_i(dc_req_i.wdata.data),
      .wuser_i(1'b0),
      .be_i   (dc_req_i.be.data),
      .rdata_o(dc_data_rdata[i]),
      .ruser_o()
    );
  end

  // --------------------------------------------------
  // D-cache valid/dirty, shared by all ways
  // --------------------------------------------------
  // Same valid/dirty value is offered to every way, enables pick the way
  always_comb begin
    for (int unsigned w = 0; w < `DC_WAYS; w++) begin
      vd_wdata[w].valid = dc_req_i.wdata.valid;
      vd_wdata[w].dirty = dc_req_i.wdata.dirty;
    end
  end

  sram #(
    .DATA_W(`DC_WAYS * $bits(vldrty_t)),
    .USER_W(1),
    .WORDS (`DC_WORDS),
    .BYTE_W(1)
  ) vldrty_sram (
    .clk_i  (clk_i),
    .req_i  (|dc_req_i.way),
    .we_i   (dc_req_i.we),
    .addr_i (dc_index),
    .wdata_i(vd_wdata),
    .wuser_i(1'b0),
    .be_i   (dc_req_i.be.vldrty),
    .rdata_o(vd_rdata),
    .ruser_o()
  );

  // --------------------------------------------------
  // I-cache tag and data
  // --------------------------------------------------
  for (genvar i = 0; i < `IC_WAYS; i++) begin : gen_ic_way
    // Valid bit sits above the tag in the stored word
    sram #(
      .DATA_W($bits(ic_tag_word_t)),
      .USER_W(1),
      .WORDS (`IC_WORDS),
      .BYTE_W(8)
    ) tag_sram (
      .clk_i  (clk_i),
      .req_i  (ic_tag_req_i.way[i]),
      .we_i   (ic_tag_req_i.we),
      .addr_i (ic_tag_req_i.index),
      .wdata_i({ic_tag_req_i.valid[i], ic_tag_req_i.tag}),
      .wuser_i(1'b0),
      .be_i   ('1),
      .rdata_o(ic_tag_rdata[i]),
      .ruser_o()
    );

    sram #(
      .DATA_W(`IC_LINE_W),
      .USER_W(`IC_USER_W),
      .WORDS (`IC_WORDS),
      .BYTE_W(8)
    ) data_sram (
      .clk_i  (clk_i),
      .req_i  (ic_data_req_i.way[i]),
      .we_i   (ic_data_req_i.we),
      .addr_i (ic_data_req_i.index),
      .wdata_i(ic_data_req_i.rtrn.data),
      .wuser_i(ic_data_req_i.rtrn.user),
      .be_i   ('1),
      .rdata_o(ic_data_rdata[i]),
      .ruser_o(ic_user_rdata[i])
    );
  end

  // Reassemble per-way read results
  always_comb begin
    for (int unsigned w = 0; w < `DC_WAYS; w++) begin
      dc_rdata_o[w].tag   = dc_tag_rdata[w];
      dc_rdata_o[w].data  = dc_data_rdata[w];
      dc_rdata_o[w].valid = vd_rdata[w].valid;
      dc_rdata_o[w].dirty = vd_rdata[w].dirty;
    end
    for (int unsigned w = 0; w < `IC_WAYS; w++) begin
      ic_tag_rdata_o[w]       = ic_tag_rdata[w];
      ic_data_rdata_o[w].data = ic_data_rdata[w];
      ic_data_rdata_o[w].user = ic_user_rdata[w];
    end
  end

  // Enabled write with no way selected would be lost silently
  dc_write_way_a: assert property (
    @(posedge clk_i) (dc_req_i.we && (|dc_req_i.be)) |-> (|dc_req_i.way)
  ) else $error("cache_ram_array: D-cache write with empty way mask");

endmodule

/* src/cache_ram_top.sv */
`include "cache_settings.svh"

module cache_ram_top (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  cache_pkg::dc_req_t                     dc_req_i,
  input  cache_pkg::ic_tag_req_t                 ic_tag_req_i,
  input  cache_pkg::ic_data_req_t                ic_data_req_i,
  output cache_pkg::dc_line_t     [`DC_WAYS-1:0] dc_rdata_o,
  output cache_pkg::ic_tag_word_t [`IC_WAYS-1:0] ic_tag_rdata_o,
  output cache_pkg::ic_rtrn_t     [`IC_WAYS-1:0] ic_data_rdata_o,
  output logic                                   ready_o
);

  import cache_pkg::*;

  dc_req_t      dc_req;
  ic_tag_req_t  ic_tag_req;
  ic_data_req_t ic_data_req;

  // --------------------------------------------------
  // Post-reset clear and request gating
  // --------------------------------------------------
  cache_ram_clear cache_ram_clear_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .dc_req_i     (dc_req_i),
    .ic_tag_req_i (ic_tag_req_i),
    .ic_data_req_i(ic_data_req_i),
    .dc_req_o     (dc_req),
    .ic_tag_req_o (ic_tag_req),
    .ic_data_req_o(ic_data_req),
    .ready_o      (ready_o)
  );

  // --------------------------------------------------
  // RAMs
  // --------------------------------------------------
  cache_ram_array cache_ram_array_inst (
    .clk_i          (clk_i),
    .dc_req_i       (dc_req),
    .ic_tag_req_i   (ic_tag_req),
    .ic_data_req_i  (ic_data_req),
    .dc_rdata_o     (dc_rdata_o),
    .ic_tag_rdata_o (ic_tag_rdata_o),
    .ic_data_rdata_o(ic_data_rdata_o)
  );

endmodule

/* tests/cache_ram_vectors.svh */
`ifndef CACHE_RAM_VECTORS_SVH
`define CACHE_RAM_VECTORS_SVH

// Row columns: D-cache request, I-cache tag request, I-cache data request,
// random data flag, outputs checked after the access

typedef enum logic [2:0] {
  CHK_NONE,
  CHK_DC,
  CHK_IC_TAG,
  CHK_IC_DATA,
  CHK_HOLD
} chk_e;

typedef struct {
  dc_req_t      dc;
  ic_tag_req_t  ic_tag;
  ic_data_req_t ic_data;
  logic         rand_data;
  chk_e         chk;
} vec_t;

vec_t vectors[$];

function automatic vec_t idle_row();
  vec_t v;
  v.dc        = '0;
  v.ic_tag    = '0;
  v.ic_data   = '0;
  v.rand_data = 1'b0;
  v.chk       = CHK_NONE;
  return v;
endfunction

// No request at all, outputs must hold
function automatic vec_t hold_row();
  vec_t v;
  v     = idle_row();
  v.chk = CHK_HOLD;
  return v;
endfunction

function automatic vec_t dc_row(input logic [`DC_WAYS-1:0] way, input logic we,
                                input int index, input dc_line_t wdata,
                                input dc_be_t be, input logic rnd);
  vec_t v;
  v             = idle_row();
  v.dc.way      = way;
  v.dc.we       = we;
  v.dc.addr     = dc_addr_t'(index) << `DC_OFFSET_W;
  v.dc.wdata    = wdata;
  v.dc.be       = be;
  v.rand_data   = rnd;
  v.chk         = we ? CHK_NONE : CHK_DC;
  return v;
endfunction

function automatic vec_t ic_tag_row(input logic [`IC_WAYS-1:0] way, input logic we,
                                    input int index, input ic_tag_t tag,
                                    input logic [`IC_WAYS-1:0] valid);
  vec_t v;
  v                = idle_row();
  v.ic_tag.way     = way;
  v.ic_tag.we      = we;
  v.ic_tag.index   = ic_index_t'(index);
  v.ic_tag.tag     = tag;
  v.ic_tag.valid   = valid;
  v.chk            = we ? CHK_NONE : CHK_IC_TAG;
  return v;
endfunction

function automatic vec_t ic_data_row(input logic [`IC_WAYS-1:0] way, input logic we,
                                     input int index, input ic_rtrn_t rtrn,
                                     input logic rnd);
  vec_t v;
  v                = idle_row();
  v.ic_data.way    = way;
  v.ic_data.we     = we;
  v.ic_data.index  = ic_index_t'(index);
  v.ic_data.rtrn   = rtrn;
  v.rand_data      = rnd;
  v.chk            = we ? CHK_NONE : CHK_IC_DATA;
  return v;
endfunction

function automatic void build_vectors();
  // Full write to way 0, way 1 untouched
  vectors.push_back(dc_row(2'b01, 1'b1, 5,
    '{tag: 8'h3c, data: 64'h0123_4567_89ab_cdef, valid: 1'b1, dirty: 1'b1},
    '{tag: 1'b1, data: 8'hff, vldrty: 4'b0011}, 1'b0));
  vectors.push_back(dc_row(2'b11, 1'b0, 5, '0, '0, 1'b0));
  vectors.push_back(hold_row());
  // Random line into way 1 at another index
  vectors.push_back(dc_row(2'b10, 1'b1, 9,
    '{tag: 8'h96, data: '0, valid: 1'b1, dirty: 1'b0}, '1, 1'b1));
  vectors.push_back(dc_row(2'b11, 1'b0, 9, '0, '0, 1'b0));
  // Partial data bytes, tag and valid/dirty disabled
  vectors.push_back(dc_row(2'b01, 1'b1, 5,
    '{tag: 8'hff, data: '0, valid: 1'b0, dirty: 1'b0},
    '{tag: 1'b0, data: 8'b0100_0101, vldrty: 4'b0000}, 1'b1));
  vectors.push_back(dc_row(2'b01, 1'b0, 5, '0, '0, 1'b0));
  // Tag byte only
  vectors.push_back(dc_row(2'b01, 1'b1, 5,
    '{tag: 8'hc3, data: '1, valid: 1'b0, dirty: 1'b0},
    '{tag: 1'b1, data: 8'h00, vldrty: 4'b0000}, 1'b0));
  vectors.push_back(dc_row(2'b01, 1'b0, 5, '0, '0, 1'b0));
  // Valid/dirty of way 1 only
  vectors.push_back(dc_row(2'b10, 1'b1, 5,
    '{tag: 8'h00, data: '0, valid: 1'b1, dirty: 1'b0},
    '{tag: 1'b0, data: 8'h00, vldrty: 4'b1100}, 1'b0));
  vectors.push_back(dc_row(2'b11, 1'b0, 5, '0, '0, 1'b0));
  // I-cache tag words with per-way valid
  vectors.push_back(ic_tag_row(2'b10, 1'b1, 3, 10'h2a5, 2'b10));
  vectors.push_back(ic_tag_row(2'b01, 1'b1, 3, 10'h155, 2'b10));
  vectors.push_back(ic_tag_row(2'b11, 1'b0, 3, '0, '0));
  vectors.push_back(hold_row());
  // I-cache data with user bits
  vectors.push_back(ic_data_row(2'b01, 1'b1, 7, '{user: 4'h5, data: '0}, 1'b1));
  vectors.push_back(ic_data_row(2'b10, 1'b1, 7, '{user: 4'ha, data: 32'hdead_beef}, 1'b0));
  vectors.push_back(ic_data_row(2'b11, 1'b0, 7, '0, 1'b0));
  vectors.push_back(hold_row());
endfunction

`endif

/* tests/cache_ram_tb.sv */
`include "cache_settings.svh"

module cache_ram_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import cache_pkg::*;

  logic                        clk_i;
  logic                        rst_i;
  dc_req_t                     dc_req_i;
  ic_tag_req_t                 ic_tag_req_i;
  ic_data_req_t                ic_data_req_i;
  dc_line_t     [`DC_WAYS-1:0] dc_rdata_o;
  ic_tag_word_t [`IC_WAYS-1:0] ic_tag_rdata_o;
  ic_rtrn_t     [`IC_WAYS-1:0] ic_data_rdata_o;
  logic                        ready_o;

  // Reference contents, all zero once the clear walk is done
  dc_line_t     dc_model  [`DC_WAYS][`DC_WORDS] = '{default: '0};
  ic_tag_word_t ict_model [`IC_WAYS][`IC_WORDS] = '{default: '0};
  ic_rtrn_t     icd_model [`IC_WAYS][`IC_WORDS] = '{default: '0};

  // Expected read results left on the outputs by the last read of each way
  dc_line_t     [`DC_WAYS-1:0] last_dc;
  ic_tag_word_t [`IC_WAYS-1:0] last_ict;
  ic_rtrn_t     [`IC_WAYS-1:0] last_icd;

  int cycles = 0;
  int timeout_limit = 1000;

  `include "cache_ram_vectors.svh"

  cache_ram_top cache_ram_top_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .dc_req_i       (dc_req_i),
    .ic_tag_req_i   (ic_tag_req_i),
    .ic_data_req_i  (ic_data_req_i),
    .dc_rdata_o     (dc_rdata_o),
    .ic_tag_rdata_o (ic_tag_rdata_o),
    .ic_data_rdata_o(ic_data_rdata_o),
    .ready_o        (ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("Regression failed");
      $fatal(1, "timeout");
    end
  end

  // --------------------------------------------------
  // Checking and reference model
  // --------------------------------------------------
  task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Regression failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic void fill_random();
    foreach (vectors[i]) begin
      if (vectors[i].rand_data) begin
        vectors[i].dc.wdata.data     = {$urandom, $urandom};
        vectors[i].ic_data.rtrn.data = $urandom;
      end
    end
  endfunction

  // Byte lanes for tag and data, single bits for valid/dirty
  function automatic void model_write(input vec_t v);
    int idx;
    idx = v.dc.addr >> `DC_OFFSET_W;
    if (v.dc.we && |v.dc.way) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        if (v.dc.way[w]) begin
          for (int b = 0; b < `DC_TAG_W; b++) begin
            if (v.dc.be.tag[b / 8]) dc_model[w][idx].tag[b] = v.dc.wdata.tag[b];
          end
          for (int b = 0; b < `DC_LINE_W; b++) begin
            if (v.dc.be.data[b / 8]) dc_model[w][idx].data[b] = v.dc.wdata.data[b];
          end
        end
        if (v.dc.be.vldrty[w].valid) dc_model[w][idx].valid = v.dc.wdata.valid;
        if (v.dc.be.vldrty[w].dirty) dc_model[w][idx].dirty = v.dc.wdata.dirty;
      end
    end
    for (int w = 0; w < `IC_WAYS; w++) begin
      if (v.ic_tag.we && v.ic_tag.way[w]) begin
        ict_model[w][v.ic_tag.index] = '{valid: v.ic_tag.valid[w], tag: v.ic_tag.tag};
      end
      if (v.ic_data.we && v.ic_data.way[w]) begin
        icd_model[w][v.ic_data.index] = v.ic_data.rtrn;
      end
    end
  endfunction

  // A read loads the output register of each selected way from the model
  function automatic void track_reads(input vec_t v);
    int idx;
    idx = v.dc.addr >> `DC_OFFSET_W;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (!v.dc.we && v.dc.way[w]) begin
        last_dc[w] = dc_model[w][idx];
      end
    end
    for (int w = 0; w < `IC_WAYS; w++) begin
      if (!v.ic_tag.we && v.ic_tag.way[w]) begin
        last_ict[w] = ict_model[w][v.ic_tag.index];
      end
      if (!v.ic_data.we && v.ic_data.way[w]) begin
        last_icd[w] = icd_model[w][v.ic_data.index];
      end
    end
  endfunction

  task automatic check_row(input int i);
    vec_t v;
    int   idx;
    v   = vectors[i];
    idx = v.dc.addr >> `DC_OFFSET_W;
    check_value(ready_o, 1'b1, $sformatf("row %0d ready_o", i));
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (v.chk == CHK_DC && v.dc.way[w]) begin
        check_value(dc_rdata_o[w], dc_model[w][idx], $sformatf("row %0d dc way %0d", i, w));
      end
      if (v.chk == CHK_IC_TAG && v.ic_tag.way[w]) begin
        check_value(ic_tag_rdata_o[w], ict_model[w][v.ic_tag.index],
                    $sformatf("row %0d ic tag way %0d", i, w));
      end
      if (v.chk == CHK_IC_DATA && v.ic_data.way[w]) begin
        check_value(ic_data_rdata_o[w], icd_model[w][v.ic_data.index],
                    $sformatf("row %0d ic data way %0d", i, w));
      end
      if (v.chk == CHK_HOLD) begin
        check_value(dc_rdata_o[w], last_dc[w], $sformatf("row %0d dc hold way %0d", i, w));
        check_value(ic_tag_rdata_o[w], last_ict[w], $sformatf("row %0d ic tag hold", i));
        check_value(ic_data_rdata_o[w], last_icd[w], $sformatf("row %0d ic data hold", i));
      end
    end
  endtask

  // One-cycle strobe, then sample after the read edge
  task automatic drive_requests(input dc_req_t dc, input ic_tag_req_t ict,
                                input ic_data_req_t icd);
    @(posedge clk_i);
    dc_req_i      <= dc;
    ic_tag_req_i  <= ict;
    ic_data_req_i <= icd;
    @(posedge clk_i);
    dc_req_i      <= '0;
    ic_tag_req_i  <= '0;
    ic_data_req_i <= '0;
    @(negedge clk_i);
  endtask

  task automatic check_cleared();
    dc_req_t      dc;
    ic_tag_req_t  ict;
    ic_data_req_t icd;
    for (int idx = 0; idx < `DC_WORDS; idx++) begin
      dc        = '0;
      dc.way    = '1;
      dc.addr   = dc_addr_t'(idx) << `DC_OFFSET_W;
      ict       = '0;
      ict.way   = '1;
      ict.index = ic_index_t'(idx);
      icd       = '0;
      icd.way   = '1;
      icd.index = ic_index_t'(idx);
      drive_requests(dc, ict, icd);
      for (int w = 0; w < `DC_WAYS; w++) begin
        check_value(dc_rdata_o[w], '0, $sformatf("clear dc index %0d way %0d", idx, w));
        check_value(ic_tag_rdata_o[w], '0, $sformatf("clear ic tag index %0d", idx));
        check_value(ic_data_rdata_o[w], '0, $sformatf("clear ic data index %0d", idx));
      end
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int waited;
    void'($urandom(39047));
    build_vectors();
    fill_random();
    timeout_limit = 5 + 16 + 4 * vectors.size() + 50;
    rst_i         = 1'b1;
    dc_req_i      = '0;
    ic_tag_req_i  = '0;
    ic_data_req_i = '0;

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check_value(ready_o, 1'b0, "ready_o during reset");
    @(posedge clk_i);
    rst_i <= 1'b0;

    // Writes issued during the walk must be dropped, up to its last cycle
    @(posedge clk_i);
    dc_req_i      <= '{way: '1, we: 1'b1, addr: '0, wdata: '1, be: '1};
    ic_tag_req_i  <= '{way: '1, we: 1'b1, index: '0, tag: '1, valid: '1};
    ic_data_req_i <= '{way: '1, we: 1'b1, index: '0, rtrn: '1};
    waited = 0;
    @(negedge clk_i);
    while (!ready_o) begin
      @(posedge clk_i);
      waited++;
      if (waited == 16) begin
        dc_req_i      <= '0;
        ic_tag_req_i  <= '0;
        ic_data_req_i <= '0;
      end
      @(negedge clk_i);
    end
    check_value(waited, 16, "cycles from first edge out of reset to ready_o");

    check_cleared();
    // Every index read back as zero
    last_dc  = '0;
    last_ict = '0;
    last_icd = '0;

    foreach (vectors[i]) begin
      drive_requests(vectors[i].dc, vectors[i].ic_tag, vectors[i].ic_data);
      model_write(vectors[i]);
      check_row(i);
      track_reads(vectors[i]);
    end

    $display("Regression passed");
    $finish;
  end

endmodule

/* all.f */
+incdir+include
+incdir+tests
src/cache_pkg.sv
src/sram.sv
src/cache_ram_clear.sv
src/cache_ram_array.sv
src/cache_ram_top.sv
tests/cache_ram_tb.sv
